/* common/fbPkg.sv */
// frame geometry, lane layout and derived widths of the colour buffer, referenced as fbPkg::NAME
package fbPkg;

    // visible frame in pixels
    localparam int DISPLAY_WIDTH = 32;  // pixels per line
    localparam int DISPLAY_HEIGHT = 16; // lines per frame

    // pixels are interleaved over the lanes, the lane of a pixel is x modulo NUM_LANES
    localparam int NUM_LANES = 4;

    // RGBA4444, one nibble per channel
    localparam int PIXEL_WIDTH = 16;
    localparam int CHANNEL_WIDTH = 4;                          // also the RAM strobe width
    localparam int NUM_CHANNELS = PIXEL_WIDTH / CHANNEL_WIDTH; // one mask bit per channel

    // coordinate widths
    localparam int X_WIDTH = $clog2(DISPLAY_WIDTH);  // 5 bits for 32 columns
    localparam int Y_WIDTH = $clog2(DISPLAY_HEIGHT); // 4 bits for 16 lines
    localparam int LANE_WIDTH = $clog2(NUM_LANES);   // low bits of x that pick the lane

    // every lane holds a quarter of the frame
    // the word address is y * (DISPLAY_WIDTH / NUM_LANES) + x / NUM_LANES,
    // which is just {y, x[X_WIDTH-1:LANE_WIDTH]} as long as the sizes are powers of two
    localparam int LANE_WORDS = (DISPLAY_WIDTH * DISPLAY_HEIGHT) / NUM_LANES;
    localparam int LANE_ADDR_WIDTH = $clog2(LANE_WORDS);

    // the RAM is sized in power-of-two bytes, so add the bytes per word to the address width
    localparam int LANE_MEM_BYTES_LOG2 = LANE_ADDR_WIDTH + $clog2(PIXEL_WIDTH / 8);

endpackage

/* dv/frameBufferTb.sv */
// directed testbench of the colour buffer, checks clears, masked pixel writes and scan-out against a frame model
module frameBufferTb;

    localparam int HALF_PERIOD = 10;
    localparam int DRIVE_DELAY = 2;                    // inputs change this long after a rising edge
    localparam int FRAME_PIXELS = fbPkg::DISPLAY_WIDTH * fbPkg::DISPLAY_HEIGHT;
    localparam int CLEAR_CYCLES = 129;                 // clearStart edge to busy low
    localparam int CLEAR_LIMIT = 200;                  // give up on busy after this many cycles
    localparam int SCAN_CYCLES = FRAME_PIXELS + 10;    // start latency, the frame and a quiet tail
    localparam int WATCHDOG_CYCLES = 5 * SCAN_CYCLES + 3 * (CLEAR_CYCLES + 2) + 2 * 220 + 1000;

    logic clk;
    logic arstN;
    logic pixelWrite;
    logic [fbPkg::X_WIDTH - 1 : 0] pixelX;
    logic [fbPkg::Y_WIDTH - 1 : 0] pixelY;
    logic [fbPkg::PIXEL_WIDTH - 1 : 0] pixelColor;
    logic [fbPkg::NUM_CHANNELS - 1 : 0] colorMask;
    logic clearStart;
    logic [fbPkg::PIXEL_WIDTH - 1 : 0] clearColor;
    logic busy;
    logic scanStart;
    logic [fbPkg::PIXEL_WIDTH - 1 : 0] pixelOut;
    logic pixelValid;
    logic frameDone;

    logic [fbPkg::PIXEL_WIDTH - 1 : 0] refFrame [FRAME_PIXELS]; // expected frame in raster order
    logic [31:0] lcgState;
    int failCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int testStartFails = 0;

    frameBuffer dut (
        .clk(clk),
        .arstN(arstN),
        .pixelWrite(pixelWrite),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor),
        .colorMask(colorMask),
        .clearStart(clearStart),
        .clearColor(clearColor),
        .busy(busy),
        .scanStart(scanStart),
        .pixelOut(pixelOut),
        .pixelValid(pixelValid),
        .frameDone(frameDone)
    );

    always #HALF_PERIOD clk = ~clk;

    // numerical recipes constants, the state holds the last value returned
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // a masked write replaces only the enabled nibbles and keeps the others
    function automatic logic [15:0] mergeChannels(input logic [15:0] old, input logic [15:0] color,
                                                   input logic [3:0] mask);
        logic [15:0] merged;
        merged = old;
        for (int k = 0; k < fbPkg::NUM_CHANNELS; k++)
        begin
            if (mask[k])
            begin
                merged[k * fbPkg::CHANNEL_WIDTH +: fbPkg::CHANNEL_WIDTH] =
                    color[k * fbPkg::CHANNEL_WIDTH +: fbPkg::CHANNEL_WIDTH];
            end
        end
        return merged;
    endfunction

    task automatic valueError(input string name, input logic [15:0] got, input logic [15:0] expected);
        $display("ERROR %s: got %h, expected %h", name, got, expected);
        failCount++;
    endtask

    task automatic wordsError(input string what);
        $display("ERROR %s", what);
        failCount++;
    endtask

    // one line per test, then the next test starts counting from here
    task automatic finishTest(input string name);
        testsRun++;
        if (failCount == testStartFails)
        begin
            $display("%-24s ok", name);
        end
        else
        begin
            testsFailed++;
            $display("%-24s %0d errors", name, failCount - testStartFails);
        end
        testStartFails = failCount;
    endtask

    // one write pulse, the model follows only because the writer is idle here
    task automatic writePixel(input logic [fbPkg::X_WIDTH - 1 : 0] x, input logic [fbPkg::Y_WIDTH - 1 : 0] y,
                              input logic [15:0] color, input logic [3:0] mask);
        int idx;
        idx = int'(y) * fbPkg::DISPLAY_WIDTH + int'(x);
        @(posedge clk);
        #DRIVE_DELAY;
        pixelWrite = 1'b1;
        pixelX = x;
        pixelY = y;
        pixelColor = color;
        colorMask = mask;
        @(posedge clk);
        #DRIVE_DELAY;
        pixelWrite = 1'b0;
        refFrame[idx] = mergeChannels(refFrame[idx], color, mask);
    endtask

    // starts a clear and times busy, with disturb set it also fires requests that must be dropped
    task automatic runClear(input logic [15:0] color, input bit disturb);
        int iter;
        int busyCycles;
        int firstBusy;
        bit fell;
        iter = 0;
        busyCycles = 0;
        firstBusy = -1;
        fell = 1'b0;
        while (!fell && iter < CLEAR_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            clearStart = (iter == 0) || (disturb && iter == 60); // second clear lands mid-run
            clearColor = (iter == 0) ? color : ~color;
            pixelWrite = disturb && (iter == 20 || iter == CLEAR_CYCLES); // last one in the tail cycle
            pixelX = 5'd9;
            pixelY = 4'd5;
            pixelColor = ~color;
            colorMask = 4'hf;
            @(negedge clk);
            if (busy)
            begin
                if (firstBusy < 0)
                    firstBusy = iter;
                busyCycles++;
            end
            else if (iter > 0)
            begin
                fell = 1'b1;
            end
            iter++;
        end
        assert (fell) else wordsError("busy never fell after clearStart");
        assert (firstBusy == 1) else wordsError($sformatf("busy rose %0d cycles after clearStart", firstBusy));
        assert (busyCycles == CLEAR_CYCLES)
            else wordsError($sformatf("busy was high for %0d cycles instead of %0d", busyCycles, CLEAR_CYCLES));
        for (int i = 0; i < FRAME_PIXELS; i++)
            refFrame[i] = color;
    endtask

    // runs one scan and checks every pixel, its timing and the frame end, optionally poking a restart
    task automatic scanAndCheck(input bit pokeMid);
        int idx;
        int firstValid;
        int doneCount;
        idx = 0;
        firstValid = -1;
        doneCount = 0;
        for (int cyc = 0; cyc < SCAN_CYCLES; cyc++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            scanStart = (cyc == 0) || (pokeMid && cyc == 300);
            @(negedge clk);
            if (frameDone)
            begin
                doneCount++;
                assert (pixelValid && idx == FRAME_PIXELS - 1)
                    else wordsError($sformatf("frameDone came at cycle %0d, not with the last pixel", cyc));
            end
            if (pixelValid)
            begin
                if (firstValid < 0)
                    firstValid = cyc;
                assert (cyc == firstValid + idx) else wordsError($sformatf("gap in pixelValid before pixel %0d", idx));
                if (idx < FRAME_PIXELS)
                begin
                    assert (pixelOut === refFrame[idx])
                        else valueError($sformatf("pixelOut pixel %0d", idx), pixelOut, refFrame[idx]);
                end
                idx++;
            end
        end
        assert (firstValid == 2) else wordsError($sformatf("first pixelValid came %0d cycles after scanStart", firstValid));
        assert (idx == FRAME_PIXELS) else wordsError($sformatf("scan gave %0d pixels instead of %0d", idx, FRAME_PIXELS));
        assert (doneCount == 1) else wordsError($sformatf("frameDone pulsed %0d times", doneCount));
    endtask

    task automatic resetStateTest();
        for (int cyc = 0; cyc < 3; cyc++)
        begin
            @(negedge clk);
            assert (busy === 1'b0) else valueError("busy", 16'(busy), 16'h0);
            assert (pixelValid === 1'b0) else valueError("pixelValid", 16'(pixelValid), 16'h0);
            assert (frameDone === 1'b0) else valueError("frameDone", 16'(frameDone), 16'h0);
        end
        finishTest("reset state");
    endtask

    task automatic clearScanTest();
        runClear(16'h5a3c, 1'b0);
        scanAndCheck(1'b0);
        finishTest("clear then scan");
    endtask

    task automatic singlePixelTest();
        writePixel(5'd0, 4'd0, 16'h1111, 4'hf);  // the four corners
        writePixel(5'd31, 4'd0, 16'h2222, 4'hf);
        writePixel(5'd0, 4'd15, 16'h3333, 4'hf);
        writePixel(5'd31, 4'd15, 16'h4444, 4'hf);
        writePixel(5'd8, 4'd2, 16'hc0de, 4'hf);  // then lanes zero to three
        writePixel(5'd5, 4'd3, 16'hbeef, 4'hf);
        writePixel(5'd10, 4'd7, 16'hf00d, 4'hf);
        writePixel(5'd15, 4'd9, 16'hcafe, 4'hf);
        scanAndCheck(1'b0);
        finishTest("single pixel writes");
    endtask

    task automatic channelMaskTest();
        writePixel(5'd3, 4'd2, 16'h1234, 4'hf);
        writePixel(5'd3, 4'd2, 16'habcd, 4'b0101); // same pixel, channels zero and two only
        writePixel(5'd7, 4'd7, 16'h9876, 4'b0000); // empty mask leaves the pixel alone
        writePixel(5'd20, 4'd11, 16'hf1e2, 4'b1000);
        writePixel(5'd31, 4'd15, 16'h0ff0, 4'b0110);
        writePixel(5'd14, 4'd6, 16'h7777, 4'b0001);
        scanAndCheck(1'b0);
        finishTest("channel mask");
    endtask

    task automatic writesDuringClearTest();
        runClear(16'h0f0f, 1'b1);
        scanAndCheck(1'b0);
        finishTest("writes during clear");
    endtask

    task automatic randomFrameTest();
        logic [31:0] place;
        logic [31:0] paint;
        paint = nextRandom();
        runClear(paint[23:8], 1'b0);
        for (int n = 0; n < 200; n++)
        begin
            place = nextRandom();
            paint = nextRandom();
            writePixel(place[12:8], place[19:16], paint[23:8], place[27:24]);
        end
        scanAndCheck(1'b1); // a second scanStart in mid-frame must change nothing
        finishTest("random frame");
    endtask

    // ends a run that stops making progress
    initial
    begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        arstN = 1'b0;
        pixelWrite = 1'b0;
        pixelX = '0;
        pixelY = '0;
        pixelColor = '0;
        colorMask = '0;
        clearStart = 1'b0;
        clearColor = '0;
        scanStart = 1'b0;
        lcgState = 32'h6ce;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;
        resetStateTest();
        clearScanTest();
        singlePixelTest();
        channelMaskTest();
        writesDuringClearTest();
        randomFrameTest();
        $display("%0d tests run, %0d with errors, %0d failed checks", testsRun, testsFailed, failCount);
        if (failCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# build the colour buffer testbench with Verilator, run it and look for the pass message in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module frameBufferTb -o frameBufferSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frameBufferSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sim.f */
common/fbPkg.sv
verilog/DualPortRam.sv
verilog/fragmentWriter.sv
verilog/scanOut.sv
verilog/frameBuffer.sv
dv/frameBufferTb.sv

/* verilog/DualPortRam.sv */
// behavioural simple dual-port RAM with a strobed write port and a registered read port
module DualPortRam #(
    parameter int MEM_SIZE_BYTES = 14,    // memory size as a power of two in bytes
    parameter int MEM_WIDTH = 16,         // word width in bits
    parameter int WRITE_STROBE_WIDTH = 4  // bits covered by one mask bit
)
(
    input  logic                                        clk,
    input  logic                                        arstN,

    // write port, a slice is stored only where writeCs, write and its mask bit are all set
    input  logic [MEM_WIDTH - 1 : 0]                    writeData,
    input  logic                                        writeCs,
    input  logic                                        write,
    input  logic [MEM_SIZE_BYTES - $clog2(MEM_WIDTH / 8) - 1 : 0] writeAddr,
    input  logic [MEM_WIDTH / WRITE_STROBE_WIDTH - 1 : 0]         writeMask,

    // read port with one cycle of latency
    output logic [MEM_WIDTH - 1 : 0]                    readData,
    input  logic                                        readCs,
    input  logic [MEM_SIZE_BYTES - $clog2(MEM_WIDTH / 8) - 1 : 0] readAddr
);
    localparam int MEM_SIZE = MEM_SIZE_BYTES - $clog2(MEM_WIDTH / 8); // address bits
    localparam int WRITE_MASK_SIZE = MEM_WIDTH / WRITE_STROBE_WIDTH;   // slices per word

    logic [MEM_WIDTH - 1 : 0] mem [1 << MEM_SIZE]; // the storage array itself

    // write side, each strobe slice has its own enable
    always_ff @(posedge clk)
    begin
        if (writeCs && write)
        begin
            for (int i = 0; i < WRITE_MASK_SIZE; i++)
            begin
                if (writeMask[i])
                begin
                    mem[writeAddr][i * WRITE_STROBE_WIDTH +: WRITE_STROBE_WIDTH] <=
                        writeData[i * WRITE_STROBE_WIDTH +: WRITE_STROBE_WIDTH];
                end
            end
        end
    end

    // read side holds its word until the next readCs
    // a read and a write to one address in the same cycle return the old word
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            readData <= '0; // output register comes up as zero
        end
        else if (readCs)
        begin
            readData <= mem[readAddr];
        end
    end

endmodule

/* verilog/fragmentWriter.sv */
// feeder of the colour buffer, turns pixel writes and clear commands into lane write cycles
module fragmentWriter
(
    input  logic                                  clk,
    input  logic                                  arstN,

    // single pixel write, taken only while busy is low
    input  logic                                  pixelWrite,
    input  logic [fbPkg::X_WIDTH - 1 : 0]         pixelX,
    input  logic [fbPkg::Y_WIDTH - 1 : 0]         pixelY,
    input  logic [fbPkg::PIXEL_WIDTH - 1 : 0]     pixelColor,
    input  logic [fbPkg::NUM_CHANNELS - 1 : 0]    colorMask,   // bit k enables nibble k

    // full frame clear, also taken only while busy is low
    input  logic                                  clearStart,
    input  logic [fbPkg::PIXEL_WIDTH - 1 : 0]     clearColor,

    output logic                                  busy,

    // shared write bus to all lanes, laneSel picks the lanes that store
    output logic [fbPkg::PIXEL_WIDTH - 1 : 0]     writeData,
    output logic [fbPkg::LANE_ADDR_WIDTH - 1 : 0] writeAddr,
    output logic [fbPkg::NUM_CHANNELS - 1 : 0]    writeMask,
    output logic                                  write,
    output logic [fbPkg::NUM_LANES - 1 : 0]       laneSel
);
    logic clearing;  // walking the address counter over the lanes
    logic clearTail; // one extra busy cycle after the last clear write
    logic [fbPkg::LANE_ADDR_WIDTH - 1 : 0] pixelAddr;  // word address of the requested pixel
    logic [fbPkg::NUM_LANES - 1 : 0]       laneDecode; // one-hot lane of the requested pixel
    logic [fbPkg::PIXEL_WIDTH - 1 : 0]     maskedColor;

    assign busy = clearing | clearTail; // requests are dropped whenever this is high

    // y selects the row of words, the upper bits of x the word inside the row
    assign pixelAddr = {pixelY, pixelX[fbPkg::X_WIDTH - 1 : fbPkg::LANE_WIDTH]};

    always_comb
    begin
        laneDecode = '0;
        laneDecode[pixelX[fbPkg::LANE_WIDTH - 1 : 0]] = 1'b1; // x modulo lane count
    end

    // disabled channels go out as zero, the RAM ignores them anyway
    always_comb
    begin
        for (int c = 0; c < fbPkg::NUM_CHANNELS; c++)
        begin
            maskedColor[c * fbPkg::CHANNEL_WIDTH +: fbPkg::CHANNEL_WIDTH] =
                {fbPkg::CHANNEL_WIDTH{colorMask[c]}} &
                pixelColor[c * fbPkg::CHANNEL_WIDTH +: fbPkg::CHANNEL_WIDTH];
        end
    end

    // control path, writeAddr doubles as the clear counter
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            clearing <= 1'b0;
            clearTail <= 1'b0;
            write <= 1'b0;
            writeAddr <= '0;
        end
        else if (clearing)
        begin
            if (&writeAddr) // last word of every lane goes in at this edge
            begin
                clearing <= 1'b0;
                clearTail <= 1'b1;
                write <= 1'b0;
            end
            else
            begin
                writeAddr <= writeAddr + 1'b1; // write stays high, one word per cycle
            end
        end
        else if (clearTail)
        begin
            clearTail <= 1'b0; // busy drops after this cycle
        end
        else if (clearStart) // a clear wins over a pixel in the same cycle
        begin
            clearing <= 1'b1;
            write <= 1'b1;
            writeAddr <= '0;
        end
        else
        begin
            write <= pixelWrite; // a pixel write lasts exactly one cycle
            if (pixelWrite)
            begin
                writeAddr <= pixelAddr;
            end
        end
    end

    // payload, loaded only when a request is taken
    always_ff @(posedge clk)
    begin
        if (!busy)
        begin
            if (clearStart)
            begin
                writeData <= clearColor;
                writeMask <= '1; // all channels
                laneSel <= '1;   // all lanes, so the counter covers the whole frame
            end
            else if (pixelWrite)
            begin
                writeData <= maskedColor;
                writeMask <= colorMask;
                laneSel <= laneDecode;
            end
        end
    end

endmodule

/* verilog/frameBuffer.sv */
// top level of the colour buffer, the fragment writer and scan-out share four interleaved RAM lanes
module frameBuffer
(
    input  logic                                  clk,
    input  logic                                  arstN,

    // pixel writes and clears from the rasterizer side
    input  logic                                  pixelWrite,
    input  logic [fbPkg::X_WIDTH - 1 : 0]         pixelX,
    input  logic [fbPkg::Y_WIDTH - 1 : 0]         pixelY,
    input  logic [fbPkg::PIXEL_WIDTH - 1 : 0]     pixelColor,
    input  logic [fbPkg::NUM_CHANNELS - 1 : 0]    colorMask,
    input  logic                                  clearStart,
    input  logic [fbPkg::PIXEL_WIDTH - 1 : 0]     clearColor,
    output logic                                  busy,       // high while a clear runs

    // display side
    input  logic                                  scanStart,
    output logic [fbPkg::PIXEL_WIDTH - 1 : 0]     pixelOut,
    output logic                                  pixelValid,
    output logic                                  frameDone
);
    // write bus, common to every lane
    logic [fbPkg::PIXEL_WIDTH - 1 : 0]     writeData;
    logic [fbPkg::LANE_ADDR_WIDTH - 1 : 0] writeAddr;
    logic [fbPkg::NUM_CHANNELS - 1 : 0]    writeMask;
    logic                                  write;
    logic [fbPkg::NUM_LANES - 1 : 0]       laneSel; // one chip select per lane

    // read bus, address shared and data returned per lane
    logic                                  readCs;
    logic [fbPkg::LANE_ADDR_WIDTH - 1 : 0] readAddr;
    logic [fbPkg::PIXEL_WIDTH - 1 : 0]     laneReadData [fbPkg::NUM_LANES];

    fragmentWriter writer (
        .clk(clk),
        .arstN(arstN),
        .pixelWrite(pixelWrite),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor),
        .colorMask(colorMask),
        .clearStart(clearStart),
        .clearColor(clearColor),
        .busy(busy),
        .writeData(writeData),
        .writeAddr(writeAddr),
        .writeMask(writeMask),
        .write(write),
        .laneSel(laneSel)
    );

    // lane n holds every pixel whose x is n modulo the lane count
    for (genvar lane = 0; lane < fbPkg::NUM_LANES; lane++)
    begin : gLane
        DualPortRam #(
            .MEM_SIZE_BYTES(fbPkg::LANE_MEM_BYTES_LOG2),
            .MEM_WIDTH(fbPkg::PIXEL_WIDTH),
            .WRITE_STROBE_WIDTH(fbPkg::CHANNEL_WIDTH)  // one strobe per colour channel
        ) laneRam (
            .clk(clk),
            .arstN(arstN),
            .writeData(writeData),
            .writeCs(laneSel[lane]),
            .write(write),
            .writeAddr(writeAddr),
            .writeMask(writeMask),
            .readData(laneReadData[lane]),
            .readCs(readCs),
            .readAddr(readAddr)
        );
    end

    scanOut scanner (
        .clk(clk),
        .arstN(arstN),
        .scanStart(scanStart),
        .readData(laneReadData),
        .readCs(readCs),
        .readAddr(readAddr),
        .pixelOut(pixelOut),
        .pixelValid(pixelValid),
        .frameDone(frameDone)
    );

endmodule

/* verilog/scanOut.sv */
// drain of the colour buffer that the top level uses to stream the lanes in raster order
module scanOut
(
    input  logic                                  clk,
    input  logic                                  arstN,

    input  logic                                  scanStart, // ignored while a scan runs

    // shared read bus with one returned word per lane
    input  logic [fbPkg::PIXEL_WIDTH - 1 : 0]     readData [fbPkg::NUM_LANES],
    output logic                                  readCs,
    output logic [fbPkg::LANE_ADDR_WIDTH - 1 : 0] readAddr,

    // display stream without back-pressure
    output logic [fbPkg::PIXEL_WIDTH - 1 : 0]     pixelOut,
    output logic                                  pixelValid,
    output logic                                  frameDone  // with the last pixel of a frame
);
    logic                                reading;   // still issuing lane reads
    logic [fbPkg::LANE_WIDTH - 1 : 0]    readPhase; // read is issued in phase zero
    logic [fbPkg::LANE_WIDTH - 1 : 0]    outPhase;  // lane currently on pixelOut
    logic                                dataFresh; // readData was updated at the last edge
    logic [fbPkg::PIXEL_WIDTH - 1 : 0]   pixelShift [fbPkg::NUM_LANES - 1]; // lanes one and up

    assign readCs = reading && (readPhase == '0);

    // the reads stop once the last word is issued, so the only lane-three pixel
    // that appears with reading low is the last pixel of the frame
    assign frameDone = pixelValid && !reading && (&outPhase);

    // lane zero goes out straight from the RAM, the rest from the shift register
    assign pixelOut = dataFresh ? readData[0] : pixelShift[0];

    // read sequencer that fetches one word of every lane each NUM_LANES cycles
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            reading <= 1'b0;
            readPhase <= '0;
            readAddr <= '0;
        end
        else if (reading)
        begin
            readPhase <= readPhase + 1'b1;
            if (&readPhase)
            begin
                readAddr <= readAddr + 1'b1; // next word is read as the current one drains
            end
            if (readCs && (&readAddr))
            begin
                reading <= 1'b0; // last word issued
            end
        end
        else if (scanStart && !pixelValid) // the tail of a running frame also blocks a start
        begin
            reading <= 1'b1;
            readPhase <= '0;
            readAddr <= '0;
        end
    end

    // output framing
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            dataFresh <= 1'b0;
            pixelValid <= 1'b0;
            outPhase <= '0;
        end
        else
        begin
            dataFresh <= readCs; // RAM latency is one cycle
            if (readCs)
            begin
                pixelValid <= 1'b1;
                outPhase <= '0;  // new word starts with lane zero
            end
            else
            begin
                if (frameDone)
                begin
                    pixelValid <= 1'b0;
                end
                if (pixelValid)
                begin
                    outPhase <= outPhase + 1'b1;
                end
            end
        end
    end

    // lanes one and up are latched while lane zero is shown and then step towards the output
    always_ff @(posedge clk)
    begin
        if (dataFresh)
        begin
            for (int k = 0; k < fbPkg::NUM_LANES - 1; k++)
            begin
                pixelShift[k] <= readData[k + 1];
            end
        end
        else
        begin
            for (int k = 0; k < fbPkg::NUM_LANES - 2; k++)
            begin
                pixelShift[k] <= pixelShift[k + 1]; // one pixel towards the output per cycle
            end
        end
    end

endmodule
